// File: logic/soc_mem_pkg.sv
package soc_mem_pkg;

    // bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // region map, byte addresses
    // window sizes come from the word counts set at the top level
    localparam logic [addr_width-1:0] flash_start = 32'h3000_0000;
    localparam logic [addr_width-1:0] sdram_start = 32'ha000_0000;

    // one-word console data register
    localparam logic [addr_width-1:0] uart_addr = 32'h1000_0000;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

// File: logic/axi_read_channel.sv
`timescale 1ns/10ps

module axi_read_channel (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [soc_mem_pkg::addr_width-1:0]  araddr,
    input  logic [7:0]                          arlen,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [soc_mem_pkg::data_width-1:0]  rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    output logic                                rd_en,
    output logic [soc_mem_pkg::addr_width-1:0]  rd_addr,
    input  logic [soc_mem_pkg::data_width-1:0]  rd_data,
    input  logic                                rd_err
);
    import soc_mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_beat
    } state_t;

    state_t                 state;
    logic [addr_width-1:0]  beat_addr;
    // beats still to come after the current one
    logic [7:0]             beats_left;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            beats_left <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (arvalid) begin
                        state      <= st_issue;
                        beats_left <= arlen;
                    end
                end
                // one word read per beat
                st_issue: begin
                    state <= st_beat;
                end
                st_beat: begin
                    if (rready) begin
                        if (beats_left == 8'd0) begin
                            state <= st_idle;
                        end else begin
                            state      <= st_issue;
                            beats_left <= beats_left - 8'd1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // burst address, incr by one word per accepted beat
    always_ff @(posedge clock) begin
        if (arvalid && arready) begin
            beat_addr <= araddr;
        end else if (rvalid && rready && !rlast) begin
            beat_addr <= beat_addr + addr_width'(4);
        end
    end

    assign arready = (state == st_idle);
    assign rd_en   = (state == st_issue);
    assign rd_addr = beat_addr;
    assign rvalid  = (state == st_beat);
    assign rlast   = rvalid && (beats_left == 8'd0);

    // banks hold their output register between reads, so the beat holds under stall
    assign rdata = rd_data;
    assign rresp = rd_err ? resp_slverr : resp_okay;

    rdata_held_while_stalled : assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// File: logic/axi_write_channel.sv
`timescale 1ns/10ps

module axi_write_channel (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [soc_mem_pkg::addr_width-1:0]  awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [soc_mem_pkg::data_width-1:0]  wdata,
    input  logic [soc_mem_pkg::strb_width-1:0]  wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    output logic                                wr_en,
    output logic [soc_mem_pkg::addr_width-1:0]  wr_addr,
    output logic [soc_mem_pkg::data_width-1:0]  wr_data,
    output logic [soc_mem_pkg::strb_width-1:0]  wr_strb,
    input  logic                                wr_err
);
    import soc_mem_pkg::*;

    // holding registers for the two request channels
    logic                   aw_full;
    logic                   w_full;
    logic [addr_width-1:0]  aw_addr_q;
    logic [data_width-1:0]  w_data_q;
    logic [strb_width-1:0]  w_strb_q;

    logic aw_take;
    logic w_take;
    logic b_done;

    assign aw_take = awvalid && awready;
    assign w_take  = wvalid && wready;
    assign b_done  = bvalid && bready;

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_full <= 1'b0;
            w_full  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= resp_okay;
        end else begin
            if (aw_take) begin
                aw_full <= 1'b1;
            end
            if (w_take) begin
                w_full <= 1'b1;
            end
            // response follows the single write cycle
            if (wr_en) begin
                bvalid <= 1'b1;
                bresp  <= wr_err ? resp_slverr : resp_okay;
            end
            // both slots free up once the master has seen b
            if (b_done) begin
                bvalid  <= 1'b0;
                aw_full <= 1'b0;
                w_full  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_take) begin
            aw_addr_q <= awaddr;
        end
        if (w_take) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
    end

    assign awready = !aw_full;
    assign wready  = !w_full;

    // fires once, bvalid blocks a repeat until the slots are cleared
    assign wr_en   = aw_full && w_full && !bvalid;
    assign wr_addr = aw_addr_q;
    assign wr_data = w_data_q;
    assign wr_strb = w_strb_q;

    bvalid_held_until_bready : assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: logic/mem_region_banks.sv
`timescale 1ns/10ps

module mem_region_banks #(
    parameter int flash_words = 1024,
    parameter int sdram_words = 2048
) (
    input  logic                                clock,
    input  logic                                rd_en,
    input  logic [soc_mem_pkg::addr_width-1:0]  rd_addr,
    output logic [soc_mem_pkg::data_width-1:0]  rd_data,
    output logic                                rd_err,
    input  logic                                wr_en,
    input  logic [soc_mem_pkg::addr_width-1:0]  wr_addr,
    input  logic [soc_mem_pkg::data_width-1:0]  wr_data,
    input  logic [soc_mem_pkg::strb_width-1:0]  wr_strb,
    output logic                                wr_err,
    output logic                                uart_valid,
    output logic [7:0]                          uart_char
);
    import soc_mem_pkg::*;

    localparam int flash_iw = $clog2(flash_words);
    localparam int sdram_iw = $clog2(sdram_words);
    localparam logic [addr_width-1:0] flash_end = flash_start + addr_width'(flash_words * 4);
    localparam logic [addr_width-1:0] sdram_end = sdram_start + addr_width'(sdram_words * 4);

    typedef enum logic [1:0] {
        reg_none,
        reg_flash,
        reg_sdram,
        reg_uart
    } region_t;

    logic [data_width-1:0] flash_mem [flash_words];
    logic [data_width-1:0] sdram_mem [sdram_words];

    function automatic region_t decode(input logic [addr_width-1:0] addr);
        region_t r;
        r = reg_none;
        if (addr >= flash_start && addr < flash_end) begin
            r = reg_flash;
        end else if (addr >= sdram_start && addr < sdram_end) begin
            r = reg_sdram;
        end else if (addr[addr_width-1:2] == uart_addr[addr_width-1:2]) begin
            r = reg_uart;
        end
        return r;
    endfunction

    region_t               rd_region;
    region_t               wr_region;
    logic [addr_width-1:0] rd_flash_off;
    logic [addr_width-1:0] rd_sdram_off;
    logic [addr_width-1:0] wr_flash_off;
    logic [addr_width-1:0] wr_sdram_off;

    assign rd_region    = decode(rd_addr);
    assign wr_region    = decode(wr_addr);
    assign rd_flash_off = rd_addr - flash_start;
    assign rd_sdram_off = rd_addr - sdram_start;
    assign wr_flash_off = wr_addr - flash_start;
    assign wr_sdram_off = wr_addr - sdram_start;

    // read port, output only moves on rd_en
    always_ff @(posedge clock) begin
        if (rd_en) begin
            rd_err <= 1'b0;
            case (rd_region)
                reg_flash: rd_data <= flash_mem[rd_flash_off[flash_iw+1:2]];
                reg_sdram: rd_data <= sdram_mem[rd_sdram_off[sdram_iw+1:2]];
                reg_uart:  rd_data <= '0;
                default: begin
                    rd_data <= '0;
                    rd_err  <= 1'b1;
                end
            endcase
        end
    end

    // write port, byte merge under strobe
    always_ff @(posedge clock) begin
        if (wr_en) begin
            for (int i = 0; i < strb_width; i++) begin
                if (wr_strb[i] && wr_region == reg_flash) begin
                    flash_mem[wr_flash_off[flash_iw+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
                end
                if (wr_strb[i] && wr_region == reg_sdram) begin
                    sdram_mem[wr_sdram_off[sdram_iw+1:2]][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // console takes byte 0 only
    always_ff @(posedge clock) begin
        uart_valid <= wr_en && (wr_region == reg_uart) && wr_strb[0];
        if (wr_en && wr_region == reg_uart && wr_strb[0]) begin
            uart_char <= wr_data[7:0];
        end
    end

    assign wr_err = (wr_region == reg_none);

    write_has_strobe : assert property (@(posedge clock) wr_en |-> (wr_strb != '0));

endmodule

// File: logic/axi_mem_slave.sv
`timescale 1ns/10ps

module axi_mem_slave #(
    parameter int flash_words = 1024,
    parameter int sdram_words = 2048
) (
    input  logic                                clock,
    input  logic                                reset,
    // read address and data
    input  logic [soc_mem_pkg::addr_width-1:0]  araddr,
    input  logic [7:0]                          arlen,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [soc_mem_pkg::data_width-1:0]  rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                rvalid,
    input  logic                                rready,
    // write address, data and response
    input  logic [soc_mem_pkg::addr_width-1:0]  awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [soc_mem_pkg::data_width-1:0]  wdata,
    input  logic [soc_mem_pkg::strb_width-1:0]  wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    // console character out
    output logic                                uart_valid,
    output logic [7:0]                          uart_char
);
    import soc_mem_pkg::*;

    logic                  rd_en;
    logic [addr_width-1:0] rd_addr;
    logic [data_width-1:0] rd_data;
    logic                  rd_err;
    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic [strb_width-1:0] wr_strb;
    logic                  wr_err;

    axi_read_channel axi_read_channel_i (
        .clock   (clock),
        .reset   (reset),
        .araddr  (araddr),
        .arlen   (arlen),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .rd_err  (rd_err)
    );

    axi_write_channel axi_write_channel_i (
        .clock   (clock),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .wr_err  (wr_err)
    );

    mem_region_banks #(
        .flash_words (flash_words),
        .sdram_words (sdram_words)
    ) mem_region_banks_i (
        .clock      (clock),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .rd_err     (rd_err),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .wr_err     (wr_err),
        .uart_valid (uart_valid),
        .uart_char  (uart_char)
    );

endmodule

// File: bench/axi_mem_slave_tb.sv
`timescale 1ns/10ps

module axi_mem_slave_tb;
    import soc_mem_pkg::*;

    localparam int flash_words    = 1024;
    localparam int sdram_words    = 2048;
    localparam int timeout_cycles = 1000;

    logic                  clock;
    logic                  reset;
    logic [addr_width-1:0] araddr;
    logic [7:0]            arlen;
    logic                  arvalid;
    logic                  arready;
    logic [data_width-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [data_width-1:0] wdata;
    logic [strb_width-1:0] wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic                  uart_valid;
    logic [7:0]            uart_char;

    // reference memory, keyed by word address, only fully written words
    logic [31:0] model_mem [int unsigned];
    logic [31:0] written [$];
    logic [7:0]  uart_expected [$];
    logic [7:0]  uart_seen [$];
    logic [31:0] lcg_state = 32'h6f171930;
    int          checked_words = 0;

    axi_mem_slave #(
        .flash_words (flash_words),
        .sdram_words (sdram_words)
    ) axi_mem_slave_i (
        .clock      (clock),
        .reset      (reset),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .uart_valid (uart_valid),
        .uart_char  (uart_char)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // console monitor, one entry per pulse
    always @(negedge clock) begin
        if (!reset && uart_valid) begin
            uart_seen.push_back(uart_char);
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned random_below(input int unsigned limit);
        return (next_random() >> 8) % limit;
    endfunction

    function automatic logic [31:0] random_mapped_addr();
        if (random_below(2) == 0) begin
            return flash_start + 32'(4 * random_below(flash_words));
        end
        return sdram_start + 32'(4 * random_below(sdram_words));
    endfunction

    // just past each window, or in a hole of the map
    function automatic logic [31:0] unmapped_addr();
        logic [31:0] offset;
        int unsigned pick;
        offset = 32'(4 * random_below(64));
        pick   = random_below(3);
        if (pick == 0) begin
            return flash_start + 32'(flash_words * 4) + offset;
        end else if (pick == 1) begin
            return sdram_start + 32'(sdram_words * 4) + offset;
        end
        return 32'h5000_0000 + offset;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0t %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, timeout_cycles);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on a timeout");
    endtask

    // aw and w go out with their own random delays, then b is collected
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
        int aw_wait;
        int w_wait;
        int waited;
        bit aw_fire;
        bit w_fire;
        bit aw_done;
        bit w_done;
        bit b_fire;
        aw_wait = int'(random_below(6));
        w_wait  = int'(random_below(6));
        aw_fire = 1'b0;
        w_fire  = 1'b0;
        aw_done = 1'b0;
        w_done  = 1'b0;
        waited  = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clock);
            if (aw_fire) begin
                awvalid <= 1'b0;
                aw_done = 1'b1;
            end else if (!aw_done && aw_wait == 0) begin
                awaddr  <= addr;
                awvalid <= 1'b1;
            end else if (!aw_done) begin
                aw_wait--;
            end
            if (w_fire) begin
                wvalid <= 1'b0;
                w_done = 1'b1;
            end else if (!w_done && w_wait == 0) begin
                wdata  <= data;
                wstrb  <= strb;
                wvalid <= 1'b1;
            end else if (!w_done) begin
                w_wait--;
            end
            if (!(aw_done && w_done)) begin
                @(negedge clock);
                aw_fire = awvalid && awready;
                w_fire  = wvalid && wready;
                waited++;
                if (waited > timeout_cycles) begin
                    report_timeout("write address and data handshakes");
                end
            end
        end
        b_fire = 1'b0;
        waited = 0;
        while (!b_fire) begin
            bready <= (random_below(4) != 0);
            @(negedge clock);
            if (bvalid && bready) begin
                b_fire = 1'b1;
                assert (bresp == exp_resp) else report_mismatch($sformatf(
                    "bresp %0d for address %h, expected %0d", bresp, addr, exp_resp));
            end
            waited++;
            if (waited > timeout_cycles) begin
                report_timeout("write response");
            end
            @(posedge clock);
        end
        bready <= 1'b0;
    endtask

    // okay write into a mapped region, with the byte merge in the model
    task automatic track_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] word;
        int i;
        write_word(addr, data, strb, resp_okay);
        if (strb == 4'hf) begin
            model_mem[addr >> 2] = data;
        end else if (model_mem.exists(addr >> 2)) begin
            word = model_mem[addr >> 2];
            for (i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    word[8*i +: 8] = data[8*i +: 8];
                end
            end
            model_mem[addr >> 2] = word;
        end
    endtask

    task automatic read_burst(input logic [31:0] addr, input logic [7:0] len,
                              input logic [1:0] exp_resp);
        int          beat;
        int          last_beat;
        int          waited;
        logic [31:0] baddr;
        logic [31:0] held_data;
        logic        held_last;
        bit          was_stalled;
        beat        = 0;
        last_beat   = int'(len);
        was_stalled = 1'b0;
        waited      = 0;
        @(posedge clock);
        araddr  <= addr;
        arlen   <= len;
        arvalid <= 1'b1;
        @(negedge clock);
        while (!arready) begin
            waited++;
            if (waited > timeout_cycles) begin
                report_timeout("read address ready");
            end
            @(negedge clock);
        end
        @(posedge clock);
        arvalid <= 1'b0;
        waited = 0;
        while (beat <= last_beat) begin
            rready <= (random_below(4) != 0);
            @(negedge clock);
            if (was_stalled) begin
                assert (rvalid && rdata == held_data && rlast == held_last)
                    else report_mismatch("r beat changed while stalled");
            end
            if (rvalid && rready) begin
                baddr = addr + 32'(4 * beat);
                assert (rlast == (beat == last_beat)) else report_mismatch($sformatf(
                    "rlast %b on beat %0d of %0d", rlast, beat, last_beat + 1));
                assert (rresp == exp_resp) else report_mismatch($sformatf(
                    "rresp %0d at %h, expected %0d", rresp, baddr, exp_resp));
                if (exp_resp == resp_slverr) begin
                    assert (rdata == 32'h0) else report_mismatch($sformatf(
                        "error read at %h returned %h", baddr, rdata));
                end else if (model_mem.exists(baddr >> 2)) begin
                    checked_words++;
                    assert (rdata == model_mem[baddr >> 2]) else report_mismatch($sformatf(
                        "read %h at %h, expected %h", rdata, baddr, model_mem[baddr >> 2]));
                end
                beat++;
                was_stalled = 1'b0;
                waited      = 0;
            end else if (rvalid) begin
                was_stalled = 1'b1;
                held_data   = rdata;
                held_last   = rlast;
            end
            waited++;
            if (waited > timeout_cycles) begin
                report_timeout("read data beat");
            end
            @(posedge clock);
        end
        rready <= 1'b0;
    endtask

    initial begin
        int          n;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] flash_block;
        logic [31:0] sdram_block;
        logic [31:0] base;
        araddr  = '0;
        arlen   = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        reset   = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (arready && awready && wready && !rvalid && !bvalid && !uart_valid)
            else report_mismatch("handshake outputs not idle after reset");

        // full-word writes, then single-beat readback
        for (n = 0; n < 200; n++) begin
            addr = random_mapped_addr();
            track_write(addr, next_random(), 4'hf);
            written.push_back(addr);
        end
        foreach (written[k]) begin
            read_burst(written[k], 8'd0, resp_okay);
        end

        // partial strobes on known words
        for (n = 0; n < 30; n++) begin
            addr = written[random_below(32'(written.size()))];
            track_write(addr, next_random(), 4'(random_below(14) + 1));
            read_burst(addr, 8'd0, resp_okay);
        end

        // contiguous blocks so every burst beat is known
        flash_block = flash_start + 32'(4 * random_below(flash_words - 64));
        sdram_block = sdram_start + 32'(4 * random_below(sdram_words - 64));
        for (n = 0; n < 48; n++) begin
            track_write(flash_block + 32'(4 * n), next_random(), 4'hf);
            track_write(sdram_block + 32'(4 * n), next_random(), 4'hf);
        end
        for (n = 0; n < 40; n++) begin
            base = (random_below(2) == 0) ? flash_block : sdram_block;
            read_burst(base + 32'(4 * random_below(32)), 8'(random_below(16)), resp_okay);
        end

        // unmapped accesses
        for (n = 0; n < 20; n++) begin
            addr = unmapped_addr();
            write_word(addr, next_random(), 4'(random_below(15) + 1), resp_slverr);
            read_burst(addr, 8'd0, resp_slverr);
        end

        // console writes, byte 0 strobe always set
        for (n = 0; n < 16; n++) begin
            data = next_random();
            write_word(uart_addr, data, 4'(random_below(16)) | 4'h1, resp_okay);
            uart_expected.push_back(data[7:0]);
        end
        repeat (3) @(posedge clock);
        assert (uart_seen.size() == uart_expected.size()) else report_mismatch($sformatf(
            "%0d console pulses, expected %0d", uart_seen.size(), uart_expected.size()));
        foreach (uart_expected[k]) begin
            assert (uart_seen[k] == uart_expected[k]) else report_mismatch($sformatf(
                "console char %0d is %h, expected %h", k, uart_seen[k], uart_expected[k]));
        end

        // memory untouched by the error and console traffic
        foreach (written[k]) begin
            read_burst(written[k], 8'd0, resp_okay);
        end
        assert (checked_words > 400) else report_mismatch($sformatf(
            "only %0d words compared against the model", checked_words));

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: list.f
logic/soc_mem_pkg.sv
logic/axi_read_channel.sv
logic/axi_write_channel.sv
logic/mem_region_banks.sv
logic/axi_mem_slave.sv
bench/axi_mem_slave_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module axi_mem_slave_tb \
        -f list.f --Mdir obj_dir -o axi_mem_slave_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/axi_mem_slave_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
